// File: hdl/mem_bus_pkg.sv
// Memory-side definitions for the instruction fetch bus.
// Imported by the requester, the output stage and the top level.

`default_nettype none

package mem_bus_pkg;

  // Bus geometry
  localparam int addr_width = 32;
  localparam int data_width = 32;

  // Granted requests that may still wait for rvalid
  localparam int max_outstanding = 2;
  localparam int outstanding_width = $clog2(max_outstanding + 1);

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [outstanding_width-1:0] outstanding_t;

  // One word per request
  localparam addr_t addr_step = addr_t'(4);

endpackage

`default_nettype wire

// File: hdl/fetch_pkg.sv
// Fetch-path definitions: buffered entry type, buffer sizing and credit width.
// Shared by the fetch stream interface and the fetch blocks.

`default_nettype none

package fetch_pkg;

  import mem_bus_pkg::*;

  // Word as returned by the bus, plus its error flag
  typedef struct packed {
    data_t rdata;
    logic  err;
  } fetch_entry_t;

  localparam int buffer_depth = 4;
  localparam int ptr_width = $clog2(buffer_depth);
  localparam int count_width = $clog2(buffer_depth + 1);

  // Room for buffer occupancy plus outstanding requests
  localparam int credit_width = count_width + 1;

  typedef logic [ptr_width-1:0] ptr_t;
  typedef logic [count_width-1:0] count_t;
  typedef logic [credit_width-1:0] credit_t;

endpackage

`default_nettype wire

// File: hdl/fetch_if.sv
// Valid/ready stream of fetch entries between two fetch blocks.
// The pop side may report its occupancy back through count.

`timescale 1ns/100ps
`default_nettype none

interface fetch_if import fetch_pkg::*; #(
  parameter bit count_used = 1'b1
) (
  input logic clk
);

  logic         valid;
  logic         ready;
  fetch_entry_t entry;
  count_t       count;

  // Stream without occupancy feedback
  if (!count_used) begin : g_count_tie
    assign count = '0;
  end

  modport push (
    input  clk,
    output valid,
    output entry,
    input  ready,
    input  count
  );

  modport pop (
    input  clk,
    input  valid,
    input  entry,
    output ready,
    output count
  );

endinterface

`default_nettype wire

// File: hdl/fetch_requester.sv
// Issues sequential word requests on the instruction bus and pushes the
// responses into the fetch buffer. Responses of a stream left by a redirect are dropped.

`timescale 1ns/100ps
`default_nettype none

module fetch_requester import mem_bus_pkg::*, fetch_pkg::*; (
  input  wire   clk,
  input  wire   reset_i,

  input  wire   redirect_i,
  input  addr_t redirect_addr_i,

  output logic  instr_req_o,
  output addr_t instr_addr_o,
  input  wire   instr_gnt_i,
  input  wire   instr_rvalid_i,
  input  data_t instr_rdata_i,
  input  wire   instr_err_i,

  fetch_if.push buf_o
);

  addr_t        next_addr_q;
  addr_t        stale_addr_q;
  logic         stale_req_q;
  logic         active_q;
  outstanding_t outstanding_q;
  outstanding_t outstanding_d;
  outstanding_t discard_q;
  credit_t      inflight;
  logic         issue_ok;
  logic         gnt_fire;
  logic         ungranted;

  // Words already claimed in the buffer
  assign inflight = credit_t'(buf_o.count) + credit_t'(outstanding_q);

  assign issue_ok = active_q && !stale_req_q &&
                    (outstanding_q < outstanding_t'(max_outstanding)) &&
                    (inflight < credit_t'(buffer_depth));

  // A request left over from before a redirect keeps the bus until granted
  assign instr_req_o  = stale_req_q | issue_ok;
  assign instr_addr_o = stale_req_q ? stale_addr_q : next_addr_q;

  assign gnt_fire  = instr_req_o & instr_gnt_i;
  assign ungranted = instr_req_o & ~instr_gnt_i;

  always_comb begin
    outstanding_d = outstanding_q;
    if (gnt_fire) begin
      outstanding_d = outstanding_d + outstanding_t'(1);
    end
    if (instr_rvalid_i) begin
      outstanding_d = outstanding_d - outstanding_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      active_q      <= 1'b0;
      stale_req_q   <= 1'b0;
      next_addr_q   <= '0;
      outstanding_q <= '0;
      discard_q     <= '0;
    end else begin
      outstanding_q <= outstanding_d;
      if (redirect_i) begin
        active_q    <= 1'b1;
        next_addr_q <= redirect_addr_i;
        stale_req_q <= ungranted;
        // Everything still in flight belongs to the old stream
        discard_q   <= outstanding_d + outstanding_t'(ungranted);
      end else begin
        if (gnt_fire) begin
          stale_req_q <= 1'b0;
        end
        if (gnt_fire && !stale_req_q) begin
          next_addr_q <= next_addr_q + addr_step;
        end
        if (instr_rvalid_i && (discard_q != '0)) begin
          discard_q <= discard_q - outstanding_t'(1);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (redirect_i) begin
      stale_addr_q <= instr_addr_o;
    end
  end

  assign buf_o.valid = instr_rvalid_i && (discard_q == '0);
  assign buf_o.entry = '{rdata: instr_rdata_i, err: instr_err_i};

  rvalid_needs_outstanding: assert property (
    @(posedge clk) disable iff (reset_i)
    instr_rvalid_i |-> (outstanding_q != '0)
  );

  // Bus protocol, also across redirects
  addr_stable_until_gnt: assert property (
    @(posedge clk) disable iff (reset_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o)
  );

endmodule

`default_nettype wire

// File: hdl/fetch_buffer.sv
// Circular FIFO of fetched words between the requester and the output stage.
// Occupancy goes back to the requester for credit; flush empties it.

`timescale 1ns/100ps
`default_nettype none

module fetch_buffer import fetch_pkg::*; (
  input  wire  clk,
  input  wire  reset_i,
  input  wire  flush_i,

  fetch_if.pop  in_i,
  fetch_if.push out_o
);

  fetch_entry_t mem_q [buffer_depth];
  ptr_t         wr_ptr_q;
  ptr_t         rd_ptr_q;
  count_t       count_q;
  logic         full;
  logic         push;
  logic         pop;

  assign full = (count_q == count_t'(buffer_depth));

  assign in_i.ready = ~full;
  assign in_i.count = count_q;

  assign push = in_i.valid & in_i.ready;
  assign pop  = out_o.valid & out_o.ready;

  assign out_o.valid = (count_q != '0);
  assign out_o.entry = mem_q[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_i.entry;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + count_t'(1);
        2'b01:   count_q <= count_q - count_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Requester credit must keep responses from hitting a full buffer
  no_push_when_full: assert property (
    @(posedge clk) disable iff (reset_i)
    in_i.valid |-> !full
  );

endmodule

`default_nettype wire

// File: hdl/fetch_out_stage.sv
// Output register of the fetch stream, with the program counter of the held word.

`timescale 1ns/100ps
`default_nettype none

module fetch_out_stage import mem_bus_pkg::*, fetch_pkg::*; (
  input  wire   clk,
  input  wire   reset_i,

  input  wire   redirect_i,
  input  addr_t redirect_addr_i,

  fetch_if.pop  in_i,

  output logic  fetch_valid_o,
  input  wire   fetch_ready_i,
  output addr_t fetch_addr_o,
  output data_t fetch_rdata_o,
  output logic  fetch_err_o
);

  logic         valid_q;
  fetch_entry_t entry_q;
  addr_t        pc_q;
  logic         accept;
  logic         consume;

  assign consume    = valid_q & fetch_ready_i;
  assign in_i.ready = ~valid_q | fetch_ready_i;
  assign accept     = in_i.valid & in_i.ready;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
      pc_q    <= '0;
    end else if (redirect_i) begin
      valid_q <= 1'b0;
      pc_q    <= redirect_addr_i;
    end else begin
      if (accept) begin
        valid_q <= 1'b1;
      end else if (consume) begin
        valid_q <= 1'b0;
      end
      if (consume) begin
        pc_q <= pc_q + addr_step;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      entry_q <= in_i.entry;
    end
  end

  assign fetch_valid_o = valid_q;
  assign fetch_addr_o  = pc_q;
  assign fetch_rdata_o = entry_q.rdata;
  assign fetch_err_o   = entry_q.err;

  // Buffer keeps its head word until this stage takes it
  head_held_until_taken: assert property (
    @(posedge clk) disable iff (reset_i)
    in_i.valid && !in_i.ready && !redirect_i |=>
      in_i.valid && $stable(in_i.entry)
  );

endmodule

`default_nettype wire

// File: hdl/fetch_unit_top.sv
// Instruction fetch unit: requester, word buffer and output register.
// Redirect restarts fetching; the stream comes out as valid/ready with address.

`timescale 1ns/100ps
`default_nettype none

module fetch_unit_top import mem_bus_pkg::*; (
  input  wire   clk,
  input  wire   reset_i,

  input  wire   redirect_i,
  input  addr_t redirect_addr_i,

  output logic  instr_req_o,
  output addr_t instr_addr_o,
  input  wire   instr_gnt_i,
  input  wire   instr_rvalid_i,
  input  data_t instr_rdata_i,
  input  wire   instr_err_i,

  output logic  fetch_valid_o,
  input  wire   fetch_ready_i,
  output addr_t fetch_addr_o,
  output data_t fetch_rdata_o,
  output logic  fetch_err_o
);

  fetch_if #(.count_used(1'b1)) req_to_buf (.clk(clk));
  fetch_if #(.count_used(1'b0)) buf_to_out (.clk(clk));

  fetch_requester i_requester (
    .clk             (clk            ),
    .reset_i         (reset_i        ),
    .redirect_i      (redirect_i     ),
    .redirect_addr_i (redirect_addr_i),
    .instr_req_o     (instr_req_o    ),
    .instr_addr_o    (instr_addr_o   ),
    .instr_gnt_i     (instr_gnt_i    ),
    .instr_rvalid_i  (instr_rvalid_i ),
    .instr_rdata_i   (instr_rdata_i  ),
    .instr_err_i     (instr_err_i    ),
    .buf_o           (req_to_buf     )
  );

  // Old-stream words are dropped on redirect
  fetch_buffer i_buffer (
    .clk     (clk       ),
    .reset_i (reset_i   ),
    .flush_i (redirect_i),
    .in_i    (req_to_buf),
    .out_o   (buf_to_out)
  );

  fetch_out_stage i_out_stage (
    .clk             (clk            ),
    .reset_i         (reset_i        ),
    .redirect_i      (redirect_i     ),
    .redirect_addr_i (redirect_addr_i),
    .in_i            (buf_to_out     ),
    .fetch_valid_o   (fetch_valid_o  ),
    .fetch_ready_i   (fetch_ready_i  ),
    .fetch_addr_o    (fetch_addr_o   ),
    .fetch_rdata_o   (fetch_rdata_o  ),
    .fetch_err_o     (fetch_err_o    )
  );

endmodule

`default_nettype wire

// File: sim/fetch_unit_tb.sv
// Testbench for the fetch unit: random bus responder, random consumer and random
// redirects, checked against an address model of the fetch stream.

`timescale 1ns/100ps
`default_nettype none

module fetch_unit_tb
  import mem_bus_pkg::*, fetch_pkg::*;
();

  localparam data_t data_key      = 32'ha5a5_0000;
  localparam int    min_accepts   = 2000;
  localparam int    min_redirects = 100;
  localparam int    max_cycles    = 200000;
  localparam int    stall_limit   = 1000;
  localparam int    idle_cycles   = 20;

  logic  clk;
  logic  reset_i;
  logic  redirect_i;
  addr_t redirect_addr_i;
  logic  instr_req_o;
  addr_t instr_addr_o;
  logic  instr_gnt_i;
  logic  instr_rvalid_i;
  data_t instr_rdata_i;
  logic  instr_err_i;
  logic  fetch_valid_o;
  logic  fetch_ready_i;
  addr_t fetch_addr_o;
  data_t fetch_rdata_o;
  logic  fetch_err_o;

  logic [31:0] lfsr_state;

  // Responder state: granted addresses in order, with the cycle each may answer
  addr_t pend_addr [$];
  int    pend_due [$];

  // Reference model
  addr_t exp_addr;
  addr_t req_addr;
  logic  stale_pending;
  addr_t stale_addr;
  int    inflight;
  int    accepts;
  int    redirects;
  int    cycle;
  int    last_accept;
  int    stall_cnt;

  // Values seen at the previous edge
  logic  prev_req;
  logic  prev_gnt;
  addr_t prev_addr;
  logic  prev_valid;
  logic  prev_ready;
  logic  prev_redirect;
  addr_t prev_fetch_addr;
  data_t prev_rdata;
  logic  prev_err;

  fetch_unit_top i_dut (
    .clk             (clk            ),
    .reset_i         (reset_i        ),
    .redirect_i      (redirect_i     ),
    .redirect_addr_i (redirect_addr_i),
    .instr_req_o     (instr_req_o    ),
    .instr_addr_o    (instr_addr_o   ),
    .instr_gnt_i     (instr_gnt_i    ),
    .instr_rvalid_i  (instr_rvalid_i ),
    .instr_rdata_i   (instr_rdata_i  ),
    .instr_err_i     (instr_err_i    ),
    .fetch_valid_o   (fetch_valid_o  ),
    .fetch_ready_i   (fetch_ready_i  ),
    .fetch_addr_o    (fetch_addr_o   ),
    .fetch_rdata_o   (fetch_rdata_o  ),
    .fetch_err_o     (fetch_err_o    )
  );

  always #50 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Memory contents and error map of the responder
  function automatic data_t word_at(input addr_t a);
    return a ^ data_key;
  endfunction

  function automatic logic err_at(input addr_t a);
    return a[7] & a[6];
  endfunction

  task automatic stop_with_failure();
    $display("Test FAILED");
    $fatal(1, "Simulation stopped at cycle %0d", cycle);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic observe_edge();
    // Ungranted request must hold
    if (prev_req && !prev_gnt) begin
      assert (instr_req_o) else begin
        $display("Bus request dropped before it was granted");
        stop_with_failure();
      end
      check_value("instr_addr_o", instr_addr_o, prev_addr);
    end
    if (instr_req_o && instr_gnt_i) begin
      if (stale_pending) begin
        check_value("instr_addr_o", instr_addr_o, stale_addr);
        stale_pending = 1'b0;
      end else begin
        check_value("instr_addr_o", instr_addr_o, req_addr);
        req_addr = req_addr + addr_step;
        inflight++;
      end
      pend_addr.push_back(instr_addr_o);
      pend_due.push_back(cycle + int'(rand_bits(2)));
    end
    if (prev_valid && !prev_ready && !prev_redirect) begin
      assert (fetch_valid_o) else begin
        $display("Fetch output dropped while the consumer was stalling");
        stop_with_failure();
      end
      check_value("fetch_addr_o", fetch_addr_o, prev_fetch_addr);
      check_value("fetch_rdata_o", fetch_rdata_o, prev_rdata);
      check_value("fetch_err_o", 32'(fetch_err_o), 32'(prev_err));
    end
    if (fetch_valid_o && fetch_ready_i) begin
      check_value("fetch_addr_o", fetch_addr_o, exp_addr);
      check_value("fetch_rdata_o", fetch_rdata_o, word_at(exp_addr));
      check_value("fetch_err_o", 32'(fetch_err_o), 32'(err_at(exp_addr)));
      exp_addr = exp_addr + addr_step;
      inflight--;
      accepts++;
      last_accept = cycle;
    end
    assert (inflight <= buffer_depth + 1) else begin
      $display("More than %0d words granted but not yet accepted", buffer_depth + 1);
      stop_with_failure();
    end
    if (redirect_i) begin
      // Request caught by the redirect stays on the bus, its word is dropped
      if (instr_req_o && !instr_gnt_i) begin
        stale_pending = 1'b1;
        stale_addr    = instr_addr_o;
      end
      exp_addr = redirect_addr_i;
      req_addr = redirect_addr_i;
      inflight = 0;
      redirects++;
    end
    prev_req        = instr_req_o;
    prev_gnt        = instr_gnt_i;
    prev_addr       = instr_addr_o;
    prev_valid      = fetch_valid_o;
    prev_ready      = fetch_ready_i;
    prev_redirect   = redirect_i;
    prev_fetch_addr = fetch_addr_o;
    prev_rdata      = fetch_rdata_o;
    prev_err        = fetch_err_o;
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    addr_t       a;
    // Grant only a request already seen waiting, so gnt never comes without req
    r = rand_bits(1);
    instr_gnt_i <= instr_req_o && !instr_gnt_i && r[0];
    if (pend_addr.size() != 0 && pend_due[0] <= cycle) begin
      a = pend_addr.pop_front();
      void'(pend_due.pop_front());
      instr_rvalid_i <= 1'b1;
      instr_rdata_i  <= word_at(a);
      instr_err_i    <= err_at(a);
    end else begin
      instr_rvalid_i <= 1'b0;
      instr_rdata_i  <= '0;
      instr_err_i    <= 1'b0;
    end
    // Consumer with occasional long stalls
    if (stall_cnt > 0) begin
      stall_cnt--;
      fetch_ready_i <= 1'b0;
    end else if (rand_bits(6) == 0) begin
      stall_cnt = 16 + int'(rand_bits(4));
      fetch_ready_i <= 1'b0;
    end else begin
      fetch_ready_i <= (rand_bits(2) != 0);
    end
    if (rand_bits(5) == 0) begin
      r = rand_bits(16);
      redirect_i      <= 1'b1;
      redirect_addr_i <= {14'h0, r[15:0], 2'b00};
    end else begin
      redirect_i <= 1'b0;
    end
  endtask

  initial begin
    logic [31:0] r;
    clk = 1'b0;
    lfsr_state = 32'h2f86fcc8;
    reset_i         <= 1'b1;
    redirect_i      <= 1'b0;
    redirect_addr_i <= '0;
    instr_gnt_i     <= 1'b0;
    instr_rvalid_i  <= 1'b0;
    instr_rdata_i   <= '0;
    instr_err_i     <= 1'b0;
    fetch_ready_i   <= 1'b0;
    exp_addr = '0;
    req_addr = '0;
    stale_pending = 1'b0;
    stale_addr = '0;
    inflight = 0;
    accepts = 0;
    redirects = 0;
    cycle = 0;
    last_accept = 0;
    stall_cnt = 0;
    prev_req = 1'b0;
    prev_gnt = 1'b0;
    prev_addr = '0;
    prev_valid = 1'b0;
    prev_ready = 1'b0;
    prev_redirect = 1'b0;
    prev_fetch_addr = '0;
    prev_rdata = '0;
    prev_err = 1'b0;

    repeat (2) @(posedge clk);
    reset_i <= 1'b0;

    // Idle until the first redirect
    for (int i = 0; i < idle_cycles; i++) begin
      @(posedge clk);
      assert (!instr_req_o && !fetch_valid_o) else begin
        $display("Bus request or fetch output active before the first redirect");
        stop_with_failure();
      end
    end
    r = rand_bits(16);
    redirect_i      <= 1'b1;
    redirect_addr_i <= {14'h0, r[15:0], 2'b00};

    while (accepts < min_accepts || redirects < min_redirects) begin
      @(posedge clk);
      cycle++;
      observe_edge();
      drive_inputs();
      assert (cycle - last_accept < stall_limit) else begin
        $display("No fetch output accepted for %0d cycles", stall_limit);
        stop_with_failure();
      end
      assert (cycle < max_cycles) else begin
        $display("Run did not complete within %0d cycles", max_cycles);
        stop_with_failure();
      end
    end

    $display("Accepted %0d outputs over %0d redirects in %0d cycles",
             accepts, redirects, cycle);
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
hdl/mem_bus_pkg.sv
hdl/fetch_pkg.sv
hdl/fetch_if.sv
hdl/fetch_requester.sv
hdl/fetch_buffer.sv
hdl/fetch_out_stage.sv
hdl/fetch_unit_top.sv
sim/fetch_unit_tb.sv

// File: Makefile
# Verilator build and run of the fetch unit testbench.
# Override any variable on the command line, e.g. make test BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

# The simulation exits with a failing status when the testbench stops on an error
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
